//--- source/pe_defs.svh
`ifndef PE_DEFS_SVH
`define PE_DEFS_SVH

// pipeline latencies, both at least 2 (two internal stages)
`define PE_MUL_LAT 4
`define PE_ADD_LAT 4

// command fifo depth, also the upstream's starting credits
`define PE_IN_DEPTH 4

// result buffer slots downstream
`define PE_OUT_CREDITS 4

`define PE_FW 32  // single precision word

`endif

//--- source/pe_fp_pkg.sv
`default_nettype none

`include "pe_defs.svh"

package pe_fp_pkg;

    // ieee754 single precision layout
    typedef struct packed {
        logic       sign;
        logic [7:0] exp;   // biased by 127
        logic [22:0] mant; // hidden one not stored
    } fp_fields_s;

    // same word, seen as raw bits on the wire or as fields in the math
    typedef union packed {
        logic [`PE_FW-1:0] raw;
        fp_fields_s        f;
    } fp_word_u;

endpackage

`default_nettype wire

//--- source/pe_ctrl_pkg.sv
`default_nettype none

package pe_ctrl_pkg;

    typedef enum logic [2:0] {
        OP_ADD  = 3'b000,
        OP_RSVD = 3'b001, // old accumulate slot, runs as nop
        OP_MUL  = 3'b010,
        OP_MACC = 3'b011,
        OP_NOP  = 3'b100
    } pe_op_e;

    // ops that produce a result and need an output credit
    function automatic logic op_is_arith(input pe_op_e op);
        return (op == OP_ADD) || (op == OP_MUL) || (op == OP_MACC);
    endfunction

endpackage

`default_nettype wire

//--- source/register_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module register_pipe #(
    parameter int W = 1,  // bits per stage
    parameter int D = 1   // number of stages
) (
    input  wire logic         i_clk,
    input  wire logic         i_rst_n,
    input  wire logic [W-1:0] i_d,
    output logic      [W-1:0] o_q
);

    generate
        if (D == 0) begin : g_thru
            assign o_q = i_d;  // zero delay
        end else begin : g_regs
            logic [W-1:0] stage [D];

            always_ff @(posedge i_clk or negedge i_rst_n) begin
                if (!i_rst_n) begin
                    for (int i = 0; i < D; i++) begin
                        stage[i] <= '0;
                    end
                end else begin
                    stage[0] <= i_d;
                    for (int i = 1; i < D; i++) begin
                        stage[i] <= stage[i-1]; // shift along
                    end
                end
            end

            assign o_q = stage[D-1];
        end
    endgenerate

endmodule

`default_nettype wire

//--- source/fp_mul.sv
`timescale 1ns/1ps
`default_nettype none

`include "pe_defs.svh"

module fp_mul
    import pe_fp_pkg::*;
(
    input  wire logic     i_clk,
    input  wire logic     i_rst_n,
    input  wire logic     i_valid,
    input  wire fp_word_u i_a,
    input  wire fp_word_u i_b,
    output logic          o_valid,
    output fp_word_u      o_p
);

    logic        s1_valid;
    logic        s1_sign;
    logic        s1_zero;     // either input zero or subnormal
    logic [9:0]  s1_exp;      // signed headroom for underflow
    logic [47:0] s1_prod;     // 24x24 mantissa product
    logic        s2_valid;
    fp_word_u    s2_p;
    logic [9:0]  n_exp;
    logic        flush;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            s1_valid <= i_valid;
            s2_valid <= s1_valid;
        end
    end

    // stage 1: sign, exponent sum, raw product
    always_ff @(posedge i_clk) begin
        s1_sign <= i_a.f.sign ^ i_b.f.sign;
        s1_zero <= (i_a.f.exp == 8'd0) || (i_b.f.exp == 8'd0);
        s1_exp  <= {2'b00, i_a.f.exp} + {2'b00, i_b.f.exp} - 10'd127;
        s1_prod <= {1'b1, i_a.f.mant} * {1'b1, i_b.f.mant};
    end

    // product of two 1.x values lies in [1,4), so at most one bit of shift
    assign n_exp = s1_prod[47] ? s1_exp + 10'd1 : s1_exp;
    assign flush = s1_zero || n_exp[9] || (n_exp == 10'd0); // underflow too

    // stage 2: normalize and truncate
    always_ff @(posedge i_clk) begin
        s2_p.f.sign <= s1_sign;
        s2_p.f.exp  <= flush ? 8'd0 : n_exp[7:0];
        s2_p.f.mant <= flush ? 23'd0 : (s1_prod[47] ? s1_prod[46:24] : s1_prod[45:23]);
    end

    register_pipe #(.W(`PE_FW + 1), .D(`PE_MUL_LAT - 2)) u_pad (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_d     ({s2_valid, s2_p.raw}),
        .o_q     ({o_valid, o_p.raw})
    );

endmodule

`default_nettype wire

//--- source/fp_add.sv
`timescale 1ns/1ps
`default_nettype none

`include "pe_defs.svh"

module fp_add
    import pe_fp_pkg::*;
(
    input  wire logic     i_clk,
    input  wire logic     i_rst_n,
    input  wire logic     i_valid,
    input  wire fp_word_u i_a,
    input  wire fp_word_u i_b,
    output logic          o_valid,
    output fp_word_u      o_s
);

    logic        a_big;          // |a| >= |b|
    fp_word_u    big;
    fp_word_u    sml;
    logic [23:0] big_m;
    logic [23:0] sml_m;
    logic [23:0] sml_al;         // smaller mantissa after alignment
    logic [7:0]  e_diff;
    logic [24:0] m_sum;
    logic        s1_valid;
    logic        s1_sign;
    logic [7:0]  s1_exp;
    logic [24:0] s1_sum;         // carry bit on top
    logic        s2_valid;
    fp_word_u    s2_s;
    logic [4:0]  lz;
    logic [9:0]  n_exp;
    logic [23:0] n_mant;
    logic        flush;

    // magnitude compare works on exp:mant as one unsigned number
    assign a_big  = (i_a.raw[30:0] >= i_b.raw[30:0]);
    assign big    = a_big ? i_a : i_b;
    assign sml    = a_big ? i_b : i_a;
    assign big_m  = (big.f.exp == 8'd0) ? 24'd0 : {1'b1, big.f.mant}; // subnormal flush
    assign sml_m  = (sml.f.exp == 8'd0) ? 24'd0 : {1'b1, sml.f.mant};
    assign e_diff = big.f.exp - sml.f.exp;
    assign sml_al = sml_m >> e_diff;  // shifted-out bits dropped
    assign m_sum  = (big.f.sign ^ sml.f.sign) ? {1'b0, big_m} - {1'b0, sml_al}
                                              : {1'b0, big_m} + {1'b0, sml_al};

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            s1_valid <= i_valid;
            s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge i_clk) begin
        s1_sign <= big.f.sign;   // result takes sign of larger operand
        s1_exp  <= big.f.exp;
        s1_sum  <= m_sum;
    end

    // stage 2 normalize: right by one on carry, else left by leading zeros
    always_comb begin
        lz = 5'd24;
        for (int i = 0; i < 24; i++) begin
            if (s1_sum[i]) lz = 5'(23 - i);  // highest set bit wins
        end
        if (s1_sum[24]) begin
            n_exp  = {2'b00, s1_exp} + 10'd1;
            n_mant = s1_sum[24:1];
        end else begin
            n_exp  = {2'b00, s1_exp} - {5'd0, lz};
            n_mant = s1_sum[23:0] << lz;
        end
        flush = (s1_sum == 25'd0) || n_exp[9] || (n_exp == 10'd0); // cancel or underflow
    end

    always_ff @(posedge i_clk) begin
        s2_s.f.sign <= flush ? 1'b0 : s1_sign;  // exact cancel gives +0
        s2_s.f.exp  <= flush ? 8'd0 : n_exp[7:0];
        s2_s.f.mant <= flush ? 23'd0 : n_mant[22:0];
    end

    register_pipe #(.W(`PE_FW + 1), .D(`PE_ADD_LAT - 2)) u_pad (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_d     ({s2_valid, s2_s.raw}),
        .o_q     ({o_valid, o_s.raw})
    );

endmodule

`default_nettype wire

//--- source/pe_type_c.sv
`timescale 1ns/1ps
`default_nettype none

`include "pe_defs.svh"

module pe_type_c
    import pe_ctrl_pkg::*;
(
    input  wire logic              i_clk,
    input  wire logic              i_rst_n,
    input  wire logic              i_issue,
    input  wire pe_op_e            i_op,
    input  wire logic [`PE_FW-1:0] i_a,
    input  wire logic [`PE_FW-1:0] i_b,
    input  wire logic [`PE_FW-1:0] i_c,
    output logic                   o_res_valid,
    output logic [`PE_FW-1:0]      o_res_data,
    output logic [`PE_FW-1:0]      o_byp_data
);

    localparam int T = `PE_MUL_LAT + `PE_ADD_LAT;  // every op takes the full path

    logic              is_add;
    logic              is_mul;
    logic              is_macc;
    logic              mul_en;
    logic              add_en;
    logic              add_en_d;    // adder enable, lined up with multiplier output
    logic              mul_vld;
    logic              mul_vld_d;
    logic              add_vld;
    logic [2:0]        op_d;        // op at adder input
    logic [2:0]        op_dd;       // op at result select
    logic [`PE_FW-1:0] a_d;
    logic [`PE_FW-1:0] b_d;
    logic [`PE_FW-1:0] c_d;
    logic [`PE_FW-1:0] prod;
    logic [`PE_FW-1:0] prod_d;
    logic [`PE_FW-1:0] sum;
    logic [`PE_FW-1:0] add_a;
    logic [`PE_FW-1:0] add_b;

    always_comb begin
        is_add  = 1'b0;
        is_mul  = 1'b0;
        is_macc = 1'b0;
        case (i_op)
            OP_ADD:  is_add  = 1'b1;
            OP_MUL:  is_mul  = 1'b1;
            OP_MACC: is_macc = 1'b1;
            default: ;  // nop and reserved do nothing
        endcase
    end

    assign mul_en = i_issue & (is_mul | is_macc);
    assign add_en = i_issue & (is_add | is_macc);

    fp_mul u_mul (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_valid (mul_en),
        .i_a     (i_a),
        .i_b     (i_b),
        .o_valid (mul_vld),
        .o_p     (prod)
    );

    // operands wait out the multiplier when they go straight to the adder
    register_pipe #(.W(2 * `PE_FW), .D(`PE_MUL_LAT)) u_ab_pipe (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_d({i_a, i_b}), .o_q({a_d, b_d})
    );
    register_pipe #(.W(`PE_FW), .D(`PE_MUL_LAT)) u_c_pipe (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_d(i_c), .o_q(c_d)
    );
    register_pipe #(.W(4), .D(`PE_MUL_LAT)) u_op_pipe (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_d({add_en, i_op}), .o_q({add_en_d, op_d})
    );
    register_pipe #(.W(3), .D(`PE_ADD_LAT)) u_op2_pipe (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_d(op_d), .o_q(op_dd)
    );

    assign add_a = (op_d == OP_MACC) ? prod : a_d;  // macc adds product + c
    assign add_b = (op_d == OP_MACC) ? c_d  : b_d;

    fp_add u_add (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_valid (add_en_d),
        .i_a     (add_a),
        .i_b     (add_b),
        .o_valid (add_vld),
        .o_s     (sum)
    );

    // plain multiply skips the adder, so it waits the adder latency here
    register_pipe #(.W(`PE_FW + 1), .D(`PE_ADD_LAT)) u_prod_pipe (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_d({mul_vld, prod}), .o_q({mul_vld_d, prod_d})
    );
    register_pipe #(.W(`PE_FW), .D(T)) u_byp_pipe (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_d(i_a), .o_q(o_byp_data)  // a rides along
    );

    assign o_res_data  = (op_dd == OP_MUL) ? prod_d : sum;
    assign o_res_valid = (op_dd == OP_MUL) ? mul_vld_d : add_vld;

endmodule

`default_nettype wire

//--- source/pe_in_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "pe_defs.svh"

module pe_in_fifo
    import pe_ctrl_pkg::*;
(
    input  wire logic              i_clk,
    input  wire logic              i_rst_n,
    input  wire logic              i_push,
    input  wire pe_op_e            i_op,
    input  wire logic [`PE_FW-1:0] i_a,
    input  wire logic [`PE_FW-1:0] i_b,
    input  wire logic [`PE_FW-1:0] i_c,
    input  wire logic              i_pop,
    output logic                   o_not_empty,
    output pe_op_e                 o_op,
    output logic [`PE_FW-1:0]      o_a,
    output logic [`PE_FW-1:0]      o_b,
    output logic [`PE_FW-1:0]      o_c,
    output logic                   o_in_credit
);

    localparam int DEPTH = `PE_IN_DEPTH;
    localparam int AW    = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    pe_op_e            op_mem [DEPTH];
    logic [`PE_FW-1:0] a_mem  [DEPTH];
    logic [`PE_FW-1:0] b_mem  [DEPTH];
    logic [`PE_FW-1:0] c_mem  [DEPTH];
    logic [AW-1:0]     wr_ptr;
    logic [AW-1:0]     rd_ptr;
    logic [AW:0]       count;
    logic              wr_en;
    logic              rd_en;

    function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] p);
        return (p == AW'(DEPTH - 1)) ? '0 : p + 1'b1;  // wrap for any depth
    endfunction

    assign wr_en       = i_push && (count != (AW+1)'(DEPTH)); // full push dropped
    assign rd_en       = i_pop && o_not_empty;
    assign o_not_empty = (count != '0);
    assign o_in_credit = i_pop;  // each pop frees one slot upstream

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) wr_ptr <= ptr_inc(wr_ptr);
            if (rd_en) rd_ptr <= ptr_inc(rd_ptr);
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;  // both or neither
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (wr_en) begin
            op_mem[wr_ptr] <= i_op;
            a_mem[wr_ptr]  <= i_a;
            b_mem[wr_ptr]  <= i_b;
            c_mem[wr_ptr]  <= i_c;
        end
    end

    // head of queue, seen by issue logic and datapath
    assign o_op = op_mem[rd_ptr];
    assign o_a  = a_mem[rd_ptr];
    assign o_b  = b_mem[rd_ptr];
    assign o_c  = c_mem[rd_ptr];

endmodule

`default_nettype wire

//--- source/pe_issue.sv
`timescale 1ns/1ps
`default_nettype none

`include "pe_defs.svh"

module pe_issue
    import pe_ctrl_pkg::*;
(
    input  wire logic   i_clk,
    input  wire logic   i_rst_n,
    input  wire logic   i_not_empty,
    input  wire pe_op_e i_op,
    input  wire logic   i_out_credit,
    output logic        o_pop,
    output logic        o_issue
);

    localparam int CW = $clog2(`PE_OUT_CREDITS + 1);

    logic [CW-1:0] credits;     // free downstream slots
    logic          arith;
    logic          have_credit;

    assign arith       = op_is_arith(i_op);
    assign have_credit = (credits != '0);

    // pipeline can't stall, so a slot is reserved before issue
    assign o_issue = i_not_empty && arith && have_credit;
    assign o_pop   = i_not_empty && (!arith || have_credit); // nops drain freely

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            credits <= CW'(`PE_OUT_CREDITS);
        end else begin
            case ({i_out_credit, o_issue})
                2'b10:   credits <= credits + 1'b1;
                2'b01:   credits <= credits - 1'b1;
                default: ;  // return and spend cancel
            endcase
        end
    end

endmodule

`default_nettype wire

//--- source/pe_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "pe_defs.svh"

module pe_top
    import pe_ctrl_pkg::*;
(
    input  wire logic              i_clk,
    input  wire logic              i_rst_n,
    input  wire logic              i_cmd_valid,
    input  wire pe_op_e            i_cmd_op,
    input  wire logic [`PE_FW-1:0] i_a,
    input  wire logic [`PE_FW-1:0] i_b,
    input  wire logic [`PE_FW-1:0] i_c,
    input  wire logic              i_out_credit,
    output logic                   o_in_credit,
    output logic                   o_res_valid,
    output logic [`PE_FW-1:0]      o_res_data,
    output logic [`PE_FW-1:0]      o_byp_data
);

    logic              not_empty;
    logic              pop;
    logic              issue;
    pe_op_e            head_op;
    logic [`PE_FW-1:0] head_a;
    logic [`PE_FW-1:0] head_b;
    logic [`PE_FW-1:0] head_c;

    pe_in_fifo u_fifo (
        .i_clk(i_clk), .i_rst_n(i_rst_n),
        .i_push(i_cmd_valid), .i_op(i_cmd_op), .i_a(i_a), .i_b(i_b), .i_c(i_c),
        .i_pop(pop), .o_not_empty(not_empty),
        .o_op(head_op), .o_a(head_a), .o_b(head_b), .o_c(head_c),
        .o_in_credit(o_in_credit)
    );

    pe_issue u_issue (
        .i_clk(i_clk), .i_rst_n(i_rst_n),
        .i_not_empty(not_empty), .i_op(head_op), .i_out_credit(i_out_credit),
        .o_pop(pop), .o_issue(issue)
    );

    pe_type_c u_dp (
        .i_clk(i_clk), .i_rst_n(i_rst_n),
        .i_issue(issue), .i_op(head_op), .i_a(head_a), .i_b(head_b), .i_c(head_c),
        .o_res_valid(o_res_valid), .o_res_data(o_res_data), .o_byp_data(o_byp_data)
    );

endmodule

`default_nettype wire

//--- verif/tb_pe_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "pe_defs.svh"

module tb_pe_top
    import pe_ctrl_pkg::*, pe_fp_pkg::*;
();

    localparam int T         = `PE_MUL_LAT + `PE_ADD_LAT;
    localparam int N_VEC     = 16;
    localparam int WD_CYCLES = N_VEC * (T + 16) + 100;  // watchdog budget
    localparam int HOLD      = 20;                       // cycles downstream sits full

    typedef struct packed {
        pe_op_e      op;
        logic        res_en;  // entry yields a result
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] res;
    } stim_s;

    logic              clk;
    logic              rst_n;
    logic              i_cmd_valid;
    pe_op_e            i_cmd_op;
    logic [`PE_FW-1:0] i_a;
    logic [`PE_FW-1:0] i_b;
    logic [`PE_FW-1:0] i_c;
    logic              i_out_credit;
    logic              o_in_credit;
    logic              o_res_valid;
    logic [`PE_FW-1:0] o_res_data;
    logic [`PE_FW-1:0] o_byp_data;

    stim_s       tbl [N_VEC];
    logic [31:0] exp_res [$];   // expected results in issue order
    logic [31:0] exp_byp [$];
    logic [16:0] lfsr;
    int          snd_credits;   // upstream credit model
    int          accepted;
    int          in_pulses;
    int          results_seen;
    int          credits_back;  // credits returned by downstream
    int          n_arith;
    int          err_reset;
    int          err_data;
    int          err_byp;
    int          err_nop;
    int          err_outcr;
    int          err_incr;
    int          tests_pass;
    int          tests_fail;

    pe_top i_pe_top (
        .i_clk(clk), .i_rst_n(rst_n),
        .i_cmd_valid(i_cmd_valid), .i_cmd_op(i_cmd_op),
        .i_a(i_a), .i_b(i_b), .i_c(i_c), .i_out_credit(i_out_credit),
        .o_in_credit(o_in_credit), .o_res_valid(o_res_valid),
        .o_res_data(o_res_data), .o_byp_data(o_byp_data)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;  // 100 ns period
    end

    // fibonacci lfsr x^17 + x^14 + 1 stepped once per bit
    function automatic int take_bits(input int n);
        int   v;
        logic fb;
        v = 0;
        for (int k = 0; k < n; k++) begin
            fb   = lfsr[16] ^ lfsr[13];
            lfsr = {lfsr[15:0], fb};
            v    = (v << 1) | int'(fb);
        end
        return v;
    endfunction

    // values picked so truncation is exact
    task automatic load_table();
        tbl[0]  = '{OP_ADD,  1'b1, 32'h3F800000, 32'h40000000, 32'h0, 32'h40400000}; // 1+2
        tbl[1]  = '{OP_MUL,  1'b1, 32'h40000000, 32'h40400000, 32'h0, 32'h40C00000}; // 2*3
        tbl[2]  = '{OP_NOP,  1'b0, 32'h40A00000, 32'h3F800000, 32'h0, 32'h0};
        tbl[3]  = '{OP_MACC, 1'b1, 32'h40000000, 32'h40400000, 32'h3F800000, 32'h40E00000};
        tbl[4]  = '{OP_ADD,  1'b1, 32'hC0400000, 32'h40400000, 32'h0, 32'h00000000}; // -3+3
        tbl[5]  = '{OP_ADD,  1'b1, 32'h40200000, 32'hBF800000, 32'h0, 32'h3FC00000}; // 2.5-1
        tbl[6]  = '{OP_RSVD, 1'b0, 32'h40E00000, 32'h40000000, 32'h0, 32'h0};
        tbl[7]  = '{OP_MUL,  1'b1, 32'h40400000, 32'h40400000, 32'h0, 32'h41100000}; // 3*3
        tbl[8]  = '{OP_MACC, 1'b1, 32'h3FC00000, 32'h40000000, 32'hC0400000, 32'h00000000};
        tbl[9]  = '{OP_ADD,  1'b1, 32'h40A00000, 32'h40E00000, 32'h0, 32'h41400000}; // 5+7
        tbl[10] = '{OP_MUL,  1'b1, 32'h3FE00000, 32'h40000000, 32'h0, 32'h40600000}; // 1.75*2
        tbl[11] = '{OP_MACC, 1'b1, 32'h3F000000, 32'h40800000, 32'h3E800000, 32'h40100000};
        tbl[12] = '{OP_NOP,  1'b0, 32'h41000000, 32'h0, 32'h0, 32'h0};
        tbl[13] = '{OP_MACC, 1'b1, 32'hC0000000, 32'h40400000, 32'h41200000, 32'h40800000};
        tbl[14] = '{OP_ADD,  1'b1, 32'hBF000000, 32'hBFC00000, 32'h0, 32'hC0000000}; // -2
        tbl[15] = '{OP_MUL,  1'b1, 32'hBF800000, 32'h3F000000, 32'h0, 32'hBF000000}; // -0.5
        n_arith = 0;
        for (int k = 0; k < N_VEC; k++) begin
            if (tbl[k].res_en) n_arith++;
        end
    endtask

    task automatic check_result();
        fp_word_u    got;
        logic [31:0] want_res;
        logic [31:0] want_byp;
        got.raw = o_res_data;
        results_seen++;
        if (results_seen > `PE_OUT_CREDITS + credits_back) begin
            err_outcr++;
            $display("%0t: result %0d came out with only %0d output credits granted",
                     $time, results_seen, `PE_OUT_CREDITS + credits_back);
        end
        if (exp_res.size() == 0) begin
            err_nop++;
            $display("%0t: result appeared with no arithmetic command outstanding", $time);
        end else begin
            want_res = exp_res.pop_front();
            want_byp = exp_byp.pop_front();
            if (got.raw !== want_res) begin
                err_data++;
                $display("** Error at %0t: o_res_data expected %h, got %h (s %b e %h m %h)",
                         $time, want_res, got.raw, got.f.sign, got.f.exp, got.f.mant);
            end
            if (o_byp_data !== want_byp) begin
                err_byp++;
                $display("** Error at %0t: o_byp_data expected %h, got %h",
                         $time, want_byp, o_byp_data);
            end
        end
    endtask

    task automatic report_test(input string name, input int errs);
        if (errs == 0) begin
            tests_pass++;
            $display("%-16s pass", name);
        end else begin
            tests_fail++;
            $display("%-16s FAIL (%0d errors)", name, errs);
        end
    endtask

    // outputs are sampled at posedge before registers move
    always @(posedge clk) begin
        if (rst_n) begin
            if (o_in_credit === 1'b1) begin
                in_pulses++;
                snd_credits++;  // slot back to upstream
            end
            if (o_res_valid === 1'b1) check_result();
        end
    end

    // downstream buffer model
    initial begin
        int gap;
        gap = 0;
        wait (rst_n === 1'b1);
        while (results_seen < `PE_OUT_CREDITS) @(negedge clk); // sit full first
        repeat (HOLD) @(negedge clk);
        forever begin
            @(negedge clk);
            if (gap == 0 && results_seen > credits_back) begin
                i_out_credit = 1'b1;
                credits_back++;
                gap = take_bits(3);  // 0..7 idle cycles
            end else begin
                i_out_credit = 1'b0;
                if (gap > 0) gap--;
            end
        end
    end

    initial begin
        repeat (WD_CYCLES) @(posedge clk);
        $display("timeout after %0d clock periods, results %0d of %0d",
                 WD_CYCLES, results_seen, n_arith);
        $display("Test failed");
        $finish;
    end

    initial begin
        int i;
        rst_n        = 1'b0;
        i_cmd_valid  = 1'b0;
        i_cmd_op     = OP_NOP;
        i_a          = '0;
        i_b          = '0;
        i_c          = '0;
        i_out_credit = 1'b0;
        lfsr         = 17'd91981;
        snd_credits  = `PE_IN_DEPTH;
        accepted     = 0;
        in_pulses    = 0;
        results_seen = 0;
        credits_back = 0;
        err_reset    = 0;
        err_data     = 0;
        err_byp      = 0;
        err_nop      = 0;
        err_outcr    = 0;
        err_incr     = 0;
        tests_pass   = 0;
        tests_fail   = 0;
        load_table();
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // nothing should move while idle after reset
        repeat (10) begin
            @(posedge clk);
            if (o_res_valid !== 1'b0 || o_in_credit !== 1'b0) begin
                err_reset++;
                $display("%0t: output active after reset with no command sent", $time);
            end
        end
        report_test("reset", err_reset);

        // sender only drives while holding a credit
        i = 0;
        while (i < N_VEC) begin
            @(negedge clk);
            if (snd_credits > 0) begin
                i_cmd_valid = 1'b1;
                i_cmd_op    = tbl[i].op;
                i_a         = tbl[i].a;
                i_b         = tbl[i].b;
                i_c         = tbl[i].c;
                snd_credits--;
                accepted++;
                if (tbl[i].res_en) begin
                    exp_res.push_back(tbl[i].res);
                    exp_byp.push_back(tbl[i].a);
                end
                i++;
            end else begin
                i_cmd_valid = 1'b0;
            end
        end
        @(negedge clk);
        i_cmd_valid = 1'b0;

        while (results_seen < n_arith || snd_credits != `PE_IN_DEPTH) @(negedge clk);
        repeat (2 * T) @(negedge clk);  // room for stray results

        if (results_seen != n_arith || exp_res.size() != 0) begin
            err_nop++;
            $display("result count %0d does not match %0d arithmetic entries",
                     results_seen, n_arith);
        end
        if (in_pulses != accepted || snd_credits != `PE_IN_DEPTH) begin
            err_incr++;
            $display("input credits off: %0d pulses for %0d commands, sender holds %0d",
                     in_pulses, accepted, snd_credits);
        end
        report_test("arithmetic", err_data);
        report_test("bypass", err_byp);
        report_test("no-op", err_nop);
        report_test("output credits", err_outcr);
        report_test("input credits", err_incr);
        $display("tests passed %0d, failed %0d, results %0d of %0d",
                 tests_pass, tests_fail, results_seen, n_arith);
        if (tests_fail == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
+incdir+source
source/pe_fp_pkg.sv
source/pe_ctrl_pkg.sv
source/register_pipe.sv
source/fp_mul.sv
source/fp_add.sv
source/pe_type_c.sv
source/pe_in_fifo.sv
source/pe_issue.sv
source/pe_top.sv
verif/tb_pe_top.sv

//--- Bender.yml
package:
  name: pe_top

sources:
  - include_dirs:
      - source
    files:
      - source/pe_fp_pkg.sv
      - source/pe_ctrl_pkg.sv
      - source/register_pipe.sv
      - source/fp_mul.sv
      - source/fp_add.sv
      - source/pe_type_c.sv
      - source/pe_in_fifo.sv
      - source/pe_issue.sv
      - source/pe_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - verif/tb_pe_top.sv
